//--- hdl/sd_phy_pkg.sv
// widths, lock count, nibble order and the nibble type for the sd host phy
package sd_phy_pkg;

  // stack side
  localparam int SD_BYTE_W = 8;    // one byte per card clock period

  // card side
  localparam int SD_DAT_PINS = 4;  // dat[3:0], also the nibble width

  // lock status
  // counted in o_out_clk_x2 edges once rst drops
  localparam int LOCK_CYCLES = 16;
  localparam int LOCK_CNT_W  = 5;  // wide enough to hold LOCK_CYCLES

  // wire order of the two nibbles of a byte
  // 1: upper nibble in the first half period, lower in the second
  // 0: lower nibble first
  localparam bit HI_NIBBLE_FIRST = 1'b1;

  // one nibble on the data pins
  typedef logic [SD_DAT_PINS-1:0] sd_nibble_t;

endpackage

//--- hdl/sd_phy_clock_ctrl.sv
// clock divider, card clock phase level and lock counter
`timescale 1ns/1ns

module sd_phy_clock_ctrl (
  input  logic o_out_clk_x2,   // double rate clock
  input  logic rst,
  output logic o_out_clk,      // stack clock, half rate
  output logic o_phy_out_clk,  // card clock, same phase as stack clock
  output logic o_locked,
  output logic o_first_half    // upper nibble phase
);

  logic [sd_phy_pkg::LOCK_CNT_W-1:0] lock_cnt;  // edges seen since reset

  // both divided clocks toggle together on every edge
  always_ff @(posedge o_out_clk_x2) begin
    if (rst) begin
      o_out_clk     <= 1'b0;
      o_phy_out_clk <= 1'b0;
      o_first_half  <= 1'b0;
    end else begin
      o_out_clk     <= ~o_out_clk;
      o_phy_out_clk <= ~o_phy_out_clk;
      // next card clock is the inverse of the current one,
      // so this tracks ~o_phy_out_clk one cycle out of reset
      o_first_half  <= o_phy_out_clk;
    end
  end

  // settle counter, stops once locked
  always_ff @(posedge o_out_clk_x2) begin
    if (rst) begin
      lock_cnt <= '0;
      o_locked <= 1'b0;
    end else if (!o_locked) begin
      lock_cnt <= lock_cnt + 1'b1;
      if (lock_cnt == sd_phy_pkg::LOCK_CNT_W'(sd_phy_pkg::LOCK_CYCLES - 1)) begin
        o_locked <= 1'b1;  // rises on edge LOCK_CYCLES after reset
      end
    end
  end

  // lock is sticky until the next reset
  a_lock_sticky : assert property (
    @(posedge o_out_clk_x2) disable iff (rst)
    $past(o_locked) |-> o_locked
  ) else $error("o_locked fell outside reset");

  // card clock keeps running once out of reset
  a_phy_clk_toggle : assert property (
    @(posedge o_out_clk_x2) disable iff (rst)
    !$past(rst) |-> (o_phy_out_clk != $past(o_phy_out_clk))
  ) else $error("o_phy_out_clk missed a toggle");

endmodule

//--- hdl/sd_phy_pin_io.sv
// registered tristate pin driver with one cycle input capture
`timescale 1ns/1ns

module sd_phy_pin_io #(
  parameter type pin_t = logic  // payload on the pin, 1 bit cmd or nibble dat
) (
  input  logic o_out_clk_x2,
  input  logic rst,
  input  logic i_dir,    // 1 = host drives the pin
  input  pin_t i_out,    // value to drive
  output pin_t o_in,     // pin value, one edge late
  inout  pin_t io_pin
);

  logic dir_q;  // registered direction
  pin_t out_q;  // registered drive value

  // direction is control state
  always_ff @(posedge o_out_clk_x2) begin
    if (rst) begin
      dir_q <= 1'b0;  // pin released in reset
    end else begin
      dir_q <= i_dir;
    end
  end

  // drive value and capture
  always_ff @(posedge o_out_clk_x2) begin
    out_q <= i_out;
    o_in  <= io_pin;  // whatever is on the wire, ours or the card's
  end

  assign io_pin = dir_q ? out_q : 'z;  // release when the card owns it

  // stack must hand over a known value whenever it takes the pin
  a_drive_known : assert property (
    @(posedge o_out_clk_x2) disable iff (rst)
    dir_q |-> !$isunknown(out_q)
  ) else $error("pin driven with unknown value");

endmodule

//--- hdl/sd_phy_data_lane.sv
// byte to nibble serializer and nibble to byte assembler for the data pins
`timescale 1ns/1ns

module sd_phy_data_lane (
  input  logic                             o_out_clk_x2,
  input  logic                             rst,
  input  logic                             i_first_half,  // first nibble slot
  input  logic                             i_dir,
  input  logic [sd_phy_pkg::SD_BYTE_W-1:0] i_data_out,
  output logic [sd_phy_pkg::SD_BYTE_W-1:0] o_data_in,
  inout  sd_phy_pkg::sd_nibble_t           io_pin
);

  logic [sd_phy_pkg::SD_BYTE_W-1:0] tx_byte_q;   // byte held for its second nibble
  sd_phy_pkg::sd_nibble_t           tx_first;    // first nibble, straight from the stack
  sd_phy_pkg::sd_nibble_t           tx_second;   // second nibble, from the held byte
  sd_phy_pkg::sd_nibble_t           tx_nib;      // to pin io
  sd_phy_pkg::sd_nibble_t           rx_nib;      // from pin io, one edge late
  sd_phy_pkg::sd_nibble_t           rx_first_q;  // first half capture

  // outgoing side
  // first nibble goes to the pin register on the same edge the byte is held,
  // so it reaches the pins right after that edge
  assign tx_first = sd_phy_pkg::HI_NIBBLE_FIRST ?
                    i_data_out[sd_phy_pkg::SD_BYTE_W-1 -: sd_phy_pkg::SD_DAT_PINS] :
                    i_data_out[sd_phy_pkg::SD_DAT_PINS-1:0];
  assign tx_second = sd_phy_pkg::HI_NIBBLE_FIRST ?
                     tx_byte_q[sd_phy_pkg::SD_DAT_PINS-1:0] :
                     tx_byte_q[sd_phy_pkg::SD_BYTE_W-1 -: sd_phy_pkg::SD_DAT_PINS];
  assign tx_nib = i_first_half ? tx_first : tx_second;

  always_ff @(posedge o_out_clk_x2) begin
    if (i_first_half) begin
      tx_byte_q <= i_data_out;  // new byte while last second nibble is on the pins
    end
  end

  sd_phy_pin_io #(
    .pin_t(sd_phy_pkg::sd_nibble_t)
  ) dat_pin_io_i (
    .o_out_clk_x2(o_out_clk_x2),
    .rst         (rst),
    .i_dir       (i_dir),
    .i_out       (tx_nib),
    .o_in        (rx_nib),
    .io_pin      (io_pin)
  );

  // incoming side
  // pin io captures every edge; first half capture is visible while
  // i_first_half is low, second half capture while it is high
  always_ff @(posedge o_out_clk_x2) begin
    if (!i_first_half) begin
      rx_first_q <= rx_nib;
    end
    if (i_first_half) begin  // second nibble now on rx_nib
      o_data_in <= sd_phy_pkg::HI_NIBBLE_FIRST ? {rx_first_q, rx_nib} :
                                                 {rx_nib, rx_first_q};
    end
  end

  // byte output moves once per card period, right after the second capture
  a_rx_update_slot : assert property (
    @(posedge o_out_clk_x2) disable iff (rst)
    $changed(o_data_in) |-> ($past(i_first_half) && !$past(i_first_half, 2))
  ) else $error("o_data_in updated outside its slot");

endmodule

//--- hdl/sd_host_phy.sv
// sd host phy top level: clock control, command pin and data lane
`timescale 1ns/1ns

module sd_host_phy (
  input  logic                             o_out_clk_x2,   // double rate clock
  input  logic                             rst,

  // stack side
  output logic                             o_locked,
  output logic                             o_out_clk,
  input  logic                             i_sd_cmd_dir,   // 1 = host owns cmd
  input  logic                             i_sd_cmd_out,
  output logic                             o_sd_cmd_in,
  input  logic                             i_sd_data_dir,  // 1 = host owns dat
  input  logic [sd_phy_pkg::SD_BYTE_W-1:0] i_sd_data_out,
  output logic [sd_phy_pkg::SD_BYTE_W-1:0] o_sd_data_in,

  // card side
  output logic                             o_phy_out_clk,
  inout  logic                             io_phy_sd_cmd,
  inout  sd_phy_pkg::sd_nibble_t           io_phy_sd_data
);

  logic first_half;  // nibble slot from clock control

  sd_phy_clock_ctrl clock_ctrl_i (
    .o_out_clk_x2 (o_out_clk_x2),
    .rst          (rst),
    .o_out_clk    (o_out_clk),
    .o_phy_out_clk(o_phy_out_clk),
    .o_locked     (o_locked),
    .o_first_half (first_half)
  );

  // single bit cmd line
  sd_phy_pin_io #(
    .pin_t(logic)
  ) cmd_pin_io_i (
    .o_out_clk_x2(o_out_clk_x2),
    .rst         (rst),
    .i_dir       (i_sd_cmd_dir),
    .i_out       (i_sd_cmd_out),
    .o_in        (o_sd_cmd_in),
    .io_pin      (io_phy_sd_cmd)
  );

  // dat[3:0], two nibbles per card clock
  sd_phy_data_lane data_lane_i (
    .o_out_clk_x2(o_out_clk_x2),
    .rst         (rst),
    .i_first_half(first_half),
    .i_dir       (i_sd_data_dir),
    .i_data_out  (i_sd_data_out),
    .o_data_in   (o_sd_data_in),
    .io_pin      (io_phy_sd_data)
  );

endmodule

//--- testbench/sd_card_model.sv
// card side pin model with lfsr driven cmd bit and nibble stream
`timescale 1ns/1ns

module sd_card_model (
  input  logic                             o_out_clk_x2,
  input  logic                             i_rst,
  input  logic                             i_card_clk,   // phy card clock
  input  logic                             i_cmd_dir,    // host direction, 1 = host
  input  logic                             i_data_dir,
  inout  logic                             io_cmd,
  inout  sd_phy_pkg::sd_nibble_t           io_data,
  output logic                             o_cmd_bit,    // what the card puts on cmd
  output sd_phy_pkg::sd_nibble_t           o_nibble,     // what the card puts on dat
  output logic [sd_phy_pkg::SD_BYTE_W-1:0] o_sent_byte   // byte being sent
);

  logic [31:0] lfsr_q;
  logic        cmd_own;  // card drives cmd, tracks host released state
  logic        dat_own;

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'ha3000000;
    end
    return n;
  endfunction

  always @(posedge o_out_clk_x2) begin : gen_stream
    logic [31:0]                      st;
    logic [sd_phy_pkg::SD_BYTE_W-1:0] nb;
    int                               k;
    st = lfsr_q;
    nb = o_sent_byte;
    o_cmd_bit <= st[0];  // new cmd bit every edge
    st = lfsr_next(st);
    if (i_card_clk) begin  // card clock falls next, upper nibble slot
      for (k = 0; k < sd_phy_pkg::SD_BYTE_W; k++) begin
        nb = {nb[sd_phy_pkg::SD_BYTE_W-2:0], st[0]};
        st = lfsr_next(st);
      end
      o_sent_byte <= nb;
      o_nibble    <= nb[sd_phy_pkg::SD_BYTE_W-1 -: sd_phy_pkg::SD_DAT_PINS];
    end else begin
      o_nibble <= o_sent_byte[sd_phy_pkg::SD_DAT_PINS-1:0];  // lower half
    end
    cmd_own <= !i_cmd_dir;  // same edge the host releases
    dat_own <= !i_data_dir;
    lfsr_q  <= i_rst ? 32'hcf3a5352 : st;
  end

  assign io_cmd  = cmd_own ? o_cmd_bit : 1'bz;
  assign io_data = dat_own ? o_nibble : 'z;

endmodule

//--- testbench/sd_host_phy_tb.sv
// testbench for the sd host phy: clock, reset, lfsr stimulus, assertions, report
`timescale 1ns/1ns

module sd_host_phy_tb;

  logic                             o_out_clk_x2;
  logic                             rst;
  logic                             i_sd_cmd_dir;
  logic                             i_sd_cmd_out;
  logic                             i_sd_data_dir;
  logic [sd_phy_pkg::SD_BYTE_W-1:0] i_sd_data_out;
  logic                             o_locked;
  logic                             o_out_clk;
  logic                             o_phy_out_clk;
  logic                             o_sd_cmd_in;
  logic [sd_phy_pkg::SD_BYTE_W-1:0] o_sd_data_in;
  wire                              io_phy_sd_cmd;
  wire  sd_phy_pkg::sd_nibble_t     io_phy_sd_data;

  logic                             card_cmd;
  sd_phy_pkg::sd_nibble_t           card_nib;
  logic [sd_phy_pkg::SD_BYTE_W-1:0] card_byte;

  // reference state built from the timing rules
  int                               edges;  // edges since rst fell, bit 0 is the card clock
  logic                             cmd_dir_d, cmd_dir_d2, cmd_out_d, card_cmd_d;
  logic                             data_dir_d;
  logic [sd_phy_pkg::SD_BYTE_W-1:0] tx_hold;  // byte sampled at first half edge
  logic [sd_phy_pkg::SD_BYTE_W-1:0] sent_d1, sent_d2, sent_d3;
  sd_phy_pkg::sd_nibble_t           tx_exp;
  logic                             tx_check, rx_check;

  logic [31:0] lfsr_q;
  string       cur_test;
  int          err_cnt, pass_cnt, fail_cnt, err_start;
  logic        lock_seen;
  int          i;

  sd_host_phy sd_host_phy_i (
    .o_out_clk_x2  (o_out_clk_x2),
    .rst           (rst),
    .o_locked      (o_locked),
    .o_out_clk     (o_out_clk),
    .i_sd_cmd_dir  (i_sd_cmd_dir),
    .i_sd_cmd_out  (i_sd_cmd_out),
    .o_sd_cmd_in   (o_sd_cmd_in),
    .i_sd_data_dir (i_sd_data_dir),
    .i_sd_data_out (i_sd_data_out),
    .o_sd_data_in  (o_sd_data_in),
    .o_phy_out_clk (o_phy_out_clk),
    .io_phy_sd_cmd (io_phy_sd_cmd),
    .io_phy_sd_data(io_phy_sd_data)
  );

  sd_card_model card_i (
    .o_out_clk_x2(o_out_clk_x2),
    .i_rst       (rst),
    .i_card_clk  (o_phy_out_clk),
    .i_cmd_dir   (i_sd_cmd_dir),
    .i_data_dir  (i_sd_data_dir),
    .io_cmd      (io_phy_sd_cmd),
    .io_data     (io_phy_sd_data),
    .o_cmd_bit   (card_cmd),
    .o_nibble    (card_nib),
    .o_sent_byte (card_byte)
  );

  initial begin
    o_out_clk_x2 = 1'b0;
    forever #20 o_out_clk_x2 = ~o_out_clk_x2;  // 40 ns period
  end

  always @(posedge o_out_clk_x2) begin
    edges      <= rst ? 0 : edges + 1;
    cmd_dir_d  <= i_sd_cmd_dir;
    cmd_dir_d2 <= cmd_dir_d;
    cmd_out_d  <= i_sd_cmd_out;
    card_cmd_d <= card_cmd;
    data_dir_d <= i_sd_data_dir;
    if (!edges[0]) begin
      tx_hold <= i_sd_data_out;  // first half edge
    end
    sent_d1 <= card_byte;
    sent_d2 <= sent_d1;
    sent_d3 <= sent_d2;
  end

  assign tx_exp = edges[0] ? tx_hold[7:4] : tx_hold[3:0];  // upper then lower

  a_lock : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    o_locked == (edges >= sd_phy_pkg::LOCK_CYCLES))
  else begin
    $display("ERR %s expected %b actual %b", cur_test,
             edges >= sd_phy_pkg::LOCK_CYCLES, o_locked);
    err_cnt++;
  end

  a_clk_equal : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    o_out_clk == o_phy_out_clk)
  else begin
    $display("ERR %s expected %b actual %b", cur_test, o_phy_out_clk, o_out_clk);
    err_cnt++;
  end

  // card clock high after every odd edge out of reset
  a_clk_toggle : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    o_phy_out_clk == edges[0])
  else begin
    $display("ERR %s expected %b actual %b", cur_test, edges[0], o_phy_out_clk);
    err_cnt++;
  end

  a_cmd_out : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    cmd_dir_d |-> io_phy_sd_cmd === cmd_out_d)
  else begin
    $display("ERR %s expected %b actual %b", cur_test, cmd_out_d, io_phy_sd_cmd);
    err_cnt++;
  end

  a_cmd_in : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    (edges >= 3 && !cmd_dir_d2) |-> o_sd_cmd_in === card_cmd_d)
  else begin
    $display("ERR %s expected %b actual %b", cur_test, card_cmd_d, o_sd_cmd_in);
    err_cnt++;
  end

  a_cmd_release : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    !cmd_dir_d |-> io_phy_sd_cmd === card_cmd)
  else begin
    $display("ERR %s expected %b actual %b", cur_test, card_cmd, io_phy_sd_cmd);
    err_cnt++;
  end

  a_dat_out : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    (tx_check && data_dir_d) |-> io_phy_sd_data === tx_exp)
  else begin
    $display("ERR %s expected %h actual %h", cur_test, tx_exp, io_phy_sd_data);
    err_cnt++;
  end

  a_dat_in : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    (rx_check && edges[0]) |-> o_sd_data_in === sent_d3)
  else begin
    $display("ERR %s expected %h actual %h", cur_test, sent_d3, o_sd_data_in);
    err_cnt++;
  end

  a_dat_release : assert property (@(posedge o_out_clk_x2) disable iff (rst)
    !data_dir_d |-> io_phy_sd_data === card_nib)
  else begin
    $display("ERR %s expected %h actual %h", cur_test, card_nib, io_phy_sd_data);
    err_cnt++;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'ha3000000;
    end
    return n;
  endfunction

  // n random bits, lfsr stepped once per bit
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    int         k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v      = {v[6:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_start) begin
      pass_cnt++;
      $display("%s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("%s: %0d errors", cur_test, err_cnt - err_start);
    end
    cur_test = "idle";
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge o_out_clk_x2);
  endtask

  initial begin
    rst = 1'b1;
    i_sd_cmd_dir = 1'b0;
    i_sd_cmd_out = 1'b0;
    i_sd_data_dir = 1'b0;
    i_sd_data_out = '0;
    tx_check = 1'b0;
    rx_check = 1'b0;
    lfsr_q = 32'hcf3a5352;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    lock_seen = 1'b0;
    cur_test = "reset";
    run_cycles(16);
    rst <= 1'b0;

    begin_test("lock");
    for (i = 0; i < 4 * sd_phy_pkg::LOCK_CYCLES && !lock_seen; i++) begin
      @(negedge o_out_clk_x2);  // settled values
      lock_seen = o_locked;
    end
    if (!lock_seen) begin
      $display("lock: timed out waiting for o_locked");
      err_cnt++;
    end
    run_cycles(8);
    end_test();

    begin_test("clock_div");
    run_cycles(40);
    end_test();

    begin_test("cmd_out");
    for (i = 0; i < 32; i++) begin
      @(posedge o_out_clk_x2);
      i_sd_cmd_dir <= 1'b1;
      i_sd_cmd_out <= take_bits(1) != 8'd0;
    end
    end_test();

    begin_test("cmd_in");
    @(posedge o_out_clk_x2);
    i_sd_cmd_dir <= 1'b0;  // card owns cmd now
    run_cycles(32);
    end_test();

    begin_test("data_out");
    @(posedge o_out_clk_x2);
    i_sd_data_dir <= 1'b1;
    tx_check      <= 1'b1;
    for (i = 0; i < 64; i++) begin  // 32 bytes, two edges each
      @(posedge o_out_clk_x2);
      i_sd_data_out <= take_bits(8);
    end
    run_cycles(3);  // last lower nibble still on the pins
    tx_check <= 1'b0;
    end_test();

    begin_test("data_in");
    @(posedge o_out_clk_x2);
    i_sd_data_dir <= 1'b0;
    run_cycles(6);  // let the capture pipeline fill with card data
    rx_check <= 1'b1;
    run_cycles(64);
    rx_check <= 1'b0;
    end_test();

    begin_test("turnaround");
    for (i = 0; i < 6; i++) begin
      @(posedge o_out_clk_x2);
      i_sd_cmd_dir  <= 1'b1;
      i_sd_data_dir <= 1'b1;
      i_sd_cmd_out  <= take_bits(1) != 8'd0;
      i_sd_data_out <= take_bits(8);
      run_cycles(3 + i);
      i_sd_cmd_dir  <= 1'b0;  // release, card takes both pins
      i_sd_data_dir <= 1'b0;
      run_cycles(4);
    end
    end_test();

    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #200000;
    $display("simulation timed out");
    $display("test failed");
    $finish;
  end

endmodule

//--- sd_host_phy.f
hdl/sd_phy_pkg.sv
hdl/sd_phy_clock_ctrl.sv
hdl/sd_phy_pin_io.sv
hdl/sd_phy_data_lane.sv
hdl/sd_host_phy.sv
testbench/sd_card_model.sv
testbench/sd_host_phy_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the sd host phy testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module sd_host_phy_tb \
  -f sd_host_phy.f \
  -o sd_host_phy_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sd_host_phy_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
